//--- include/imgproc_consts.svh
`ifndef IMGPROC_CONSTS_SVH
`define IMGPROC_CONSTS_SVH

// Image geometry and message rate
`define IMAGE_W         640
`define MSG_INTERVAL    6
`define MSG_FIFO_DEPTH  256

// Hue windows in units of 1/1020 of a turn
// Red window wraps through zero
`define HUE_RED_LO      1000
`define HUE_RED_HI      20
`define HUE_GREEN_LO    300
`define HUE_GREEN_HI    380
`define HUE_BLUE_LO     640
`define HUE_BLUE_HI     720

// Shared saturation and value floors
`define SAT_MIN         600
`define VAL_MIN         400

// Host register map
`define ADDR_STATUS     0
`define ADDR_MSG        1
`define ADDR_ID         2

`define IMGPROC_ID      32'h1234EEE2

// Status write bit that empties the message FIFO
`define FLUSH_BIT       4

`endif

//--- hdl/pixel_pkg.sv
package pixel_pkg;

	typedef logic [7:0] channel_t;

	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} pixel_t;

	// One beat of the video stream
	typedef struct packed {
		pixel_t pixel;
		logic   sop;
		logic   eop;
	} stream_beat_t;

	typedef logic [9:0]  hue_t;
	typedef logic [10:0] sat_t;
	typedef logic [9:0]  val_t;
	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t x_min;
		coord_t x_max;
	} extent_t;

	typedef enum logic [1:0] {
		colour_red   = 2'd0,
		colour_green = 2'd1,
		colour_blue  = 2'd2
	} colour_e;

endpackage

//--- hdl/host_pkg.sv
package host_pkg;
	import pixel_pkg::*;

	typedef logic [31:0] word_t;
	typedef logic [1:0]  reg_addr_t;

	typedef struct packed {
		logic      chipselect;
		logic      read;
		logic      write;
		reg_addr_t address;
		word_t     writedata;
	} host_req_t;

	typedef logic [8:0] fifo_level_t;

	// Tag 1 is red, 2 is green, 3 is blue
	typedef struct packed {
		logic [4:0] tag;
		coord_t     x_min;
		logic [4:0] pad;
		coord_t     x_max;
	} msg_word_t;

	typedef enum logic [1:0] {
		msg_idle,
		msg_send_red,
		msg_send_green,
		msg_send_blue
	} msg_state_e;

endpackage

//--- hdl/stream_reg.sv
`timescale 1ns/1ps

module stream_reg
	import pixel_pkg::*;
(
	input  logic         clk,
	input  logic         reset_n,
	input  stream_beat_t in_beat,
	input  logic         in_valid,
	output logic         in_ready,
	output stream_beat_t out_beat,
	output logic         out_valid,
	input  logic         out_ready
);

	stream_beat_t skid_beat_q;
	logic         skid_valid_q;
	logic         in_fire;
	logic         load_out;

	assign in_fire = in_valid & in_ready;
	// Output stage takes a new beat when empty or when its beat leaves
	assign load_out = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid    <= 1'b0;
			skid_valid_q <= 1'b0;
			in_ready     <= 1'b0;
		end else if (load_out) begin
			out_valid    <= skid_valid_q | in_fire;
			skid_valid_q <= 1'b0;
			in_ready     <= 1'b1;
		end else if (in_fire) begin
			// Output stalled, park the beat in the skid entry
			skid_valid_q <= 1'b1;
			in_ready     <= 1'b0;
		end else begin
			in_ready <= ~skid_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		if (load_out) begin
			out_beat <= skid_valid_q ? skid_beat_q : in_beat;
		end else if (in_fire) begin
			skid_beat_q <= in_beat;
		end
	end

endmodule

//--- hdl/colour_classifier.sv
`timescale 1ns/1ps
`include "imgproc_consts.svh"

module colour_classifier
	import pixel_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  pixel_t     pixel,
	input  logic       pixel_beat,
	output logic [2:0] on
);

	channel_t    cmax;
	channel_t    cmin;
	channel_t    delta;
	channel_t    hue_diff;
	logic        hue_neg;
	logic [11:0] hue_base;
	logic [11:0] hue_wide;
	logic [15:0] hue_scaled;
	logic [17:0] sat_num;
	hue_t        hue;
	sat_t        sat;
	val_t        val;
	logic        sv_ok;
	logic [2:0]  match;
	logic [3:0]  hist_q [3];

	//////////////////////////////
	// RGB to HSV

	always_comb begin
		cmax = (pixel.red >= pixel.green && pixel.red >= pixel.blue) ? pixel.red :
			(pixel.green >= pixel.blue) ? pixel.green : pixel.blue;
		cmin = (pixel.red <= pixel.green && pixel.red <= pixel.blue) ? pixel.red :
			(pixel.green <= pixel.blue) ? pixel.green : pixel.blue;
		delta = cmax - cmin;
	end

	// Hue sector follows the largest channel
	always_comb begin
		if (cmax == pixel.red) begin
			hue_base = 12'd1020;
			hue_neg  = pixel.green < pixel.blue;
			hue_diff = hue_neg ? pixel.blue - pixel.green : pixel.green - pixel.blue;
		end else if (cmax == pixel.green) begin
			hue_base = 12'd340;
			hue_neg  = pixel.blue < pixel.red;
			hue_diff = hue_neg ? pixel.red - pixel.blue : pixel.blue - pixel.red;
		end else begin
			hue_base = 12'd680;
			hue_neg  = pixel.red < pixel.green;
			hue_diff = hue_neg ? pixel.green - pixel.red : pixel.red - pixel.green;
		end
	end

	assign hue_scaled = (delta == 8'd0) ? 16'd0 : (16'd170 * {8'd0, hue_diff}) / {8'd0, delta};
	assign hue_wide = hue_neg ? hue_base - hue_scaled[11:0] : hue_base + hue_scaled[11:0];
	// Wrap at a full turn
	assign hue = (delta == 8'd0) ? '0 :
		hue_t'((hue_wide >= 12'd1020) ? hue_wide - 12'd1020 : hue_wide);

	assign sat_num = {delta, 10'd0};
	assign sat = (cmax == 8'd0) ? '0 : sat_t'(sat_num / {10'd0, cmax});
	assign val = {cmax, 2'b00};

	//////////////////////////////
	// Threshold windows

	assign sv_ok = (sat >= sat_t'(`SAT_MIN)) && (val >= val_t'(`VAL_MIN));

	assign match[colour_red] = sv_ok &&
		(hue >= hue_t'(`HUE_RED_LO) || hue <= hue_t'(`HUE_RED_HI));
	assign match[colour_green] = sv_ok &&
		(hue >= hue_t'(`HUE_GREEN_LO) && hue <= hue_t'(`HUE_GREEN_HI));
	assign match[colour_blue] = sv_ok &&
		(hue >= hue_t'(`HUE_BLUE_LO) && hue <= hue_t'(`HUE_BLUE_HI));

	// Persistence history over the four previous pixels
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int c = 0; c < 3; c++) begin
				hist_q[c] <= '0;
			end
		end else if (pixel_beat) begin
			for (int c = 0; c < 3; c++) begin
				hist_q[c] <= {hist_q[c][2:0], match[c]};
			end
		end
	end

	always_comb begin
		for (int c = 0; c < 3; c++) begin
			on[c] = match[c] & (&hist_q[c]);
		end
	end

endmodule

//--- hdl/scan_counter.sv
`timescale 1ns/1ps
`include "imgproc_consts.svh"

module scan_counter
	import pixel_pkg::*;
#(
	parameter int image_w      = `IMAGE_W,
	parameter int msg_interval = `MSG_INTERVAL
) (
	input  logic         clk,
	input  logic         reset_n,
	input  stream_beat_t beat,
	input  logic         beat_valid,
	output coord_t       x,
	output logic         pixel_beat,
	output logic         frame_end,
	output logic         msg_due
);

	logic       video_q;
	logic [7:0] frames_left_q;

	// Pixels of video packets only, the header is not a pixel
	assign pixel_beat = beat_valid & ~beat.sop & video_q;
	assign frame_end  = pixel_beat & beat.eop;
	assign msg_due    = frame_end & (frames_left_q == 8'd0);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x             <= '0;
			video_q       <= 1'b0;
			frames_left_q <= 8'(msg_interval - 1);
		end else begin
			if (beat_valid && beat.sop) begin
				x       <= '0;
				// Video packets carry a zero low nibble in the header
				video_q <= beat.pixel.blue[3:0] == 4'd0;
			end else if (pixel_beat) begin
				x <= (x == coord_t'(image_w - 1)) ? '0 : x + 1'b1;
			end
			if (frame_end) begin
				frames_left_q <= msg_due ? 8'(msg_interval - 1) : frames_left_q - 1'b1;
			end
		end
	end

endmodule

//--- hdl/extent_tracker.sv
`timescale 1ns/1ps
`include "imgproc_consts.svh"

module extent_tracker
	import pixel_pkg::*;
#(
	parameter int image_w = `IMAGE_W
) (
	input  logic    clk,
	input  logic    reset_n,
	input  coord_t  x,
	input  logic    hit,
	input  logic    pixel_beat,
	input  logic    frame_end,
	output extent_t extent
);

	localparam coord_t  last_col     = coord_t'(image_w - 1);
	// Inverted extent, reported when the colour never shows up
	localparam extent_t empty_extent = '{x_min: last_col, x_max: coord_t'(0)};

	extent_t run_q;
	extent_t run_next;

	always_comb begin
		run_next = run_q;
		if (pixel_beat && hit) begin
			if (x < run_q.x_min) begin
				run_next.x_min = x;
			end
			if (x > run_q.x_max) begin
				run_next.x_max = x;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run_q  <= empty_extent;
			extent <= empty_extent;
		end else if (frame_end) begin
			extent <= run_next;
			run_q  <= empty_extent;
		end else begin
			run_q <= run_next;
		end
	end

endmodule

//--- hdl/msg_writer.sv
`timescale 1ns/1ps
`include "imgproc_consts.svh"

module msg_writer
	import pixel_pkg::*, host_pkg::*;
(
	input  logic          clk,
	input  logic          reset_n,
	input  logic          msg_due,
	input  fifo_level_t   fifo_level,
	input  extent_t [2:0] extents,
	output logic          wr_en,
	output msg_word_t     wr_word
);

	msg_state_e state_q;
	msg_state_e state_next;
	colour_e    colour;
	logic [4:0] tag;
	logic       room;

	// A burst needs three free words
	assign room = fifo_level < fifo_level_t'(`MSG_FIFO_DEPTH - 3);

	always_comb begin
		state_next = state_q;
		case (state_q)
			msg_idle:       state_next = (msg_due && room) ? msg_send_red : msg_idle;
			msg_send_red:   state_next = msg_send_green;
			msg_send_green: state_next = msg_send_blue;
			default:        state_next = msg_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= msg_idle;
		end else begin
			state_q <= state_next;
		end
	end

	// Colour and tag of the word sent in this state
	always_comb begin
		wr_en  = 1'b1;
		colour = colour_red;
		tag    = 5'd1;
		case (state_q)
			msg_send_green: begin
				colour = colour_green;
				tag    = 5'd2;
			end
			msg_send_blue: begin
				colour = colour_blue;
				tag    = 5'd3;
			end
			msg_send_red: begin
				colour = colour_red;
			end
			default: wr_en = 1'b0;
		endcase
	end

	assign wr_word = wr_en ? '{tag: tag, x_min: extents[colour].x_min, pad: 5'd0,
		x_max: extents[colour].x_max} : '0;

endmodule

//--- hdl/host_port.sv
`timescale 1ns/1ps
`include "imgproc_consts.svh"

module host_port
	import host_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  host_req_t   req,
	output word_t       readdata,
	input  logic        wr_en,
	input  msg_word_t   wr_word,
	output fifo_level_t fifo_level
);

	localparam int depth = `MSG_FIFO_DEPTH;
	localparam int ptr_w = $clog2(depth);

	word_t            mem [depth];
	logic [ptr_w-1:0] wr_ptr_q;
	logic [ptr_w-1:0] rd_ptr_q;
	logic             rd_req;
	logic             rd_req_q;
	logic             wr_req;
	logic             flush;
	logic             empty;
	logic             push;
	logic             pop;

	assign rd_req = req.chipselect & req.read;
	assign wr_req = req.chipselect & req.write;
	assign flush  = wr_req && (req.address == reg_addr_t'(`ADDR_STATUS)) &&
		req.writedata[`FLUSH_BIT];
	assign empty  = fifo_level == '0;
	assign push   = wr_en && (fifo_level != fifo_level_t'(depth));
	// One pop per read request, taken on its first cycle
	assign pop    = rd_req && !rd_req_q && (req.address == reg_addr_t'(`ADDR_MSG)) && !empty;

	//////////////////////////////
	// Message FIFO

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			fifo_level <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   fifo_level <= fifo_level + 1'b1;
				2'b01:   fifo_level <= fifo_level - 1'b1;
				default: fifo_level <= fifo_level;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr_q] <= wr_word;
		end
	end

	//////////////////////////////
	// Register reads

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= '0;
			rd_req_q <= 1'b0;
		end else begin
			rd_req_q <= rd_req;
			// A held message read keeps the word it popped
			if (rd_req && (req.address != reg_addr_t'(`ADDR_MSG) || !rd_req_q)) begin
				case (req.address)
					reg_addr_t'(`ADDR_STATUS): readdata <= {16'd0, fifo_level[7:0], 8'd0};
					reg_addr_t'(`ADDR_MSG):    readdata <= empty ? '0 : mem[rd_ptr_q];
					reg_addr_t'(`ADDR_ID):     readdata <= `IMGPROC_ID;
					default:                   readdata <= '0;
				endcase
			end
		end
	end

endmodule

//--- hdl/imgproc_top.sv
`timescale 1ns/1ps
`include "imgproc_consts.svh"

module imgproc_top
	import pixel_pkg::*, host_pkg::*;
#(
	parameter int image_w      = `IMAGE_W,
	parameter int msg_interval = `MSG_INTERVAL
) (
	input  logic         clk,
	input  logic         reset_n,
	input  stream_beat_t sink_beat,
	input  logic         sink_valid,
	output logic         sink_ready,
	output stream_beat_t source_beat,
	output logic         source_valid,
	input  logic         source_ready,
	input  host_req_t    host_req,
	output word_t        host_readdata
);

	stream_beat_t  mid_beat;
	logic          mid_valid;
	logic          mid_ready;
	logic          beat_valid;
	coord_t        x;
	logic          pixel_beat;
	logic          frame_end;
	logic          msg_due;
	logic [2:0]    colour_on;
	extent_t [2:0] extents;
	logic          wr_en;
	msg_word_t     wr_word;
	fifo_level_t   fifo_level;

	//////////////////////////////
	// Video path

	stream_reg in_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_beat   (sink_beat),
		.in_valid  (sink_valid),
		.in_ready  (sink_ready),
		.out_beat  (mid_beat),
		.out_valid (mid_valid),
		.out_ready (mid_ready)
	);

	stream_reg out_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_beat   (mid_beat),
		.in_valid  (mid_valid),
		.in_ready  (mid_ready),
		.out_beat  (source_beat),
		.out_valid (source_valid),
		.out_ready (source_ready)
	);

	// Analysis sees the beat as it moves between the two registers
	assign beat_valid = mid_valid & mid_ready;

	//////////////////////////////
	// Analysis

	scan_counter #(
		.image_w      (image_w),
		.msg_interval (msg_interval)
	) scan_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.beat       (mid_beat),
		.beat_valid (beat_valid),
		.x          (x),
		.pixel_beat (pixel_beat),
		.frame_end  (frame_end),
		.msg_due    (msg_due)
	);

	colour_classifier classifier_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.pixel      (mid_beat.pixel),
		.pixel_beat (pixel_beat),
		.on         (colour_on)
	);

	// One tracker per colour, indexed like colour_e
	for (genvar c = 0; c < 3; c++) begin : g_extent
		extent_tracker #(
			.image_w (image_w)
		) extent_i (
			.clk        (clk),
			.reset_n    (reset_n),
			.x          (x),
			.hit        (colour_on[c]),
			.pixel_beat (pixel_beat),
			.frame_end  (frame_end),
			.extent     (extents[c])
		);
	end

	//////////////////////////////
	// Messages and host access

	msg_writer writer_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.msg_due    (msg_due),
		.fifo_level (fifo_level),
		.extents    (extents),
		.wr_en      (wr_en),
		.wr_word    (wr_word)
	);

	host_port host_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.req        (host_req),
		.readdata   (host_readdata),
		.wr_en      (wr_en),
		.wr_word    (wr_word),
		.fifo_level (fifo_level)
	);

endmodule

//--- testbench/imgproc_assert.sv
`timescale 1ns/1ps

module imgproc_assert
	import pixel_pkg::*;
(
	input logic         clk,
	input logic         reset_n,
	input logic         sink_ready,
	input stream_beat_t source_beat,
	input logic         source_valid,
	input logic         source_ready
);

	int fail_count = 0;

	//////////////////////////////
	// Source handshake

	// A stalled beat stays on the bus unchanged
	property source_hold_p;
		@(posedge clk) disable iff (!reset_n)
		source_valid && !source_ready |=> source_valid && $stable(source_beat);
	endproperty

	source_hold_a: assert property (source_hold_p)
		else begin
			fail_count++;
			$error("Source beat changed or dropped while stalled");
		end

	//////////////////////////////
	// Reset behaviour

	reset_valid_a: assert property (@(posedge clk) !reset_n |=> !source_valid)
		else begin
			fail_count++;
			$error("source_valid high after a reset cycle");
		end

	// Input side opens one cycle after reset is released
	sink_open_a: assert property (@(posedge clk) $rose(reset_n) |=> sink_ready)
		else begin
			fail_count++;
			$error("sink_ready low in the first cycle after reset");
		end

endmodule

bind imgproc_top imgproc_assert assert_i (
	.clk          (clk),
	.reset_n      (reset_n),
	.sink_ready   (sink_ready),
	.source_beat  (source_beat),
	.source_valid (source_valid),
	.source_ready (source_ready)
);

//--- testbench/imgproc_tb.sv
`timescale 1ns/1ps
`include "imgproc_consts.svh"

module imgproc_tb
	import pixel_pkg::*, host_pkg::*;
();

	localparam int image_w      = 16;
	localparam int msg_interval = 2;
	localparam int rows         = 3;
	localparam int timeout      = 2000;

	logic         clk = 1'b0;
	logic         reset_n;
	stream_beat_t sink_beat;
	logic         sink_valid;
	logic         sink_ready;
	stream_beat_t source_beat;
	logic         source_valid;
	logic         source_ready = 1'b0;
	host_req_t    host_req;
	word_t        host_readdata;

	stream_beat_t expected_q [$];
	logic [31:0]  ready_state = 32'hecf2;
	logic [31:0]  gap_state   = 32'hecf2;

	imgproc_top #(
		.image_w      (image_w),
		.msg_interval (msg_interval)
	) dut_i (
		.clk           (clk),
		.reset_n       (reset_n),
		.sink_beat     (sink_beat),
		.sink_valid    (sink_valid),
		.sink_ready    (sink_ready),
		.source_beat   (source_beat),
		.source_valid  (source_valid),
		.source_ready  (source_ready),
		.host_req      (host_req),
		.host_readdata (host_readdata)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Tag, x_min, five zero bits, x_max
	function automatic word_t expected_word(input logic [4:0] tag, input int lo, input int hi);
		coord_t x_min;
		coord_t x_max;
		// The first hit comes on the fifth pixel of a run
		if (hi - lo + 1 >= 5) begin
			x_min = coord_t'(lo + 4);
			x_max = coord_t'(hi);
		end else begin
			x_min = coord_t'(image_w - 1);
			x_max = '0;
		end
		return {tag, x_min, 5'd0, x_max};
	endfunction

	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Bound protocol assertions on the top-level ports
	always @(dut_i.assert_i.fail_count) begin
		if (dut_i.assert_i.fail_count != 0) begin
			$display("A protocol assertion on the top-level ports failed");
			stop_with_failure();
		end
	end

	//////////////////////////////
	// Stream side

	// Random back-pressure with ready about three cycles in four
	always @(negedge clk) begin
		source_ready <= ready_state[17] | ready_state[18];
		ready_state  <= lcg_next(ready_state);
	end

	always @(posedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			if (expected_q.size() == 0) begin
				$display("A beat left the source although none was sent");
				stop_with_failure();
			end else begin
				check_value("pass_through", 32'(expected_q[0]), 32'(source_beat));
				expected_q.delete(0);
			end
		end
	end

	task automatic send_beat(input stream_beat_t beat);
		int   cycles;
		logic taken;
		gap_state = lcg_next(gap_state);
		if (gap_state[17:16] == 2'd0) begin
			sink_valid = 1'b0;
			@(negedge clk);
		end
		sink_beat  = beat;
		sink_valid = 1'b1;
		cycles     = 0;
		taken      = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = sink_ready;
			if (taken) begin
				expected_q.push_back(beat);
			end
			@(negedge clk);
			cycles++;
			if (!taken && cycles > timeout) begin
				$display("Timeout: the sink never accepted a beat");
				stop_with_failure();
			end
		end
	endtask

	// Header, then rows of black with a red, green and blue run in rows 0, 1 and 2
	task automatic send_packet(input logic [7:0] header_blue, input int r_lo, input int r_hi,
		input int g_lo, input int g_hi, input int b_lo, input int b_hi);
		stream_beat_t beat;
		beat = '0;
		beat.sop = 1'b1;
		beat.pixel.blue = header_blue;
		send_beat(beat);
		for (int row = 0; row < rows; row++) begin
			for (int col = 0; col < image_w; col++) begin
				beat = '0;
				if (row == 0 && col >= r_lo && col <= r_hi) begin
					beat.pixel.red = 8'hff;
				end
				if (row == 1 && col >= g_lo && col <= g_hi) begin
					beat.pixel.green = 8'hff;
				end
				if (row == 2 && col >= b_lo && col <= b_hi) begin
					beat.pixel.blue = 8'hff;
				end
				beat.eop = (row == rows - 1) && (col == image_w - 1);
				send_beat(beat);
			end
		end
		sink_valid = 1'b0;
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout) begin
				$display("Timeout: sent beats never left the source");
				stop_with_failure();
			end
		end
		// Message words land within three cycles of the last frame end
		repeat (4) @(negedge clk);
	endtask

	//////////////////////////////
	// Host side

	task automatic host_read(input reg_addr_t address, output word_t data);
		host_req = '0;
		host_req.chipselect = 1'b1;
		host_req.read = 1'b1;
		host_req.address = address;
		@(negedge clk);
		data = host_readdata;
		host_req = '0;
		@(negedge clk);
	endtask

	task automatic host_write(input reg_addr_t address, input word_t data);
		host_req = '0;
		host_req.chipselect = 1'b1;
		host_req.write = 1'b1;
		host_req.address = address;
		host_req.writedata = data;
		@(negedge clk);
		host_req = '0;
	endtask

	task automatic check_messages(input int r_lo, input int r_hi, input int g_lo,
		input int g_hi, input int b_lo, input int b_hi);
		word_t data;
		host_read(reg_addr_t'(`ADDR_STATUS), data);
		check_value("status_level_three", 32'h0000_0300, data);
		host_read(reg_addr_t'(`ADDR_MSG), data);
		check_value("msg_red", expected_word(5'd1, r_lo, r_hi), data);
		host_read(reg_addr_t'(`ADDR_MSG), data);
		check_value("msg_green", expected_word(5'd2, g_lo, g_hi), data);
		host_read(reg_addr_t'(`ADDR_MSG), data);
		check_value("msg_blue", expected_word(5'd3, b_lo, b_hi), data);
		host_read(reg_addr_t'(`ADDR_STATUS), data);
		check_value("status_level_zero", 32'd0, data);
	endtask

	initial begin
		word_t data;
		reset_n    = 1'b0;
		sink_beat  = '0;
		sink_valid = 1'b0;
		host_req   = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		check_value("reset_readdata", 32'd0, host_readdata);
		host_read(reg_addr_t'(`ADDR_ID), data);
		check_value("id_register", `IMGPROC_ID, data);

		// One video frame and a non-video packet complete no interval
		send_packet(8'h00, 2, 9, 5, 12, 0, 6);
		send_packet(8'h0f, 0, 15, 0, 15, 0, 15);
		wait_for_drain();
		host_read(reg_addr_t'(`ADDR_STATUS), data);
		check_value("status_after_non_video", 32'd0, data);

		send_packet(8'h00, 3, 10, 6, 14, 1, 8);
		wait_for_drain();
		check_messages(3, 10, 6, 14, 1, 8);

		// Last frame of this interval has no blue run
		send_packet(8'h00, 2, 9, 5, 12, 0, 6);
		send_packet(8'h00, 4, 11, 2, 7, 1, 0);
		wait_for_drain();
		check_messages(4, 11, 2, 7, 1, 0);

		//////////////////////////////
		// Flush

		send_packet(8'h00, 0, 4, 8, 15, 3, 9);
		send_packet(8'h00, 1, 6, 0, 10, 6, 13);
		wait_for_drain();
		host_read(reg_addr_t'(`ADDR_STATUS), data);
		check_value("status_before_flush", 32'h0000_0300, data);
		host_write(reg_addr_t'(`ADDR_STATUS), 32'd1 << `FLUSH_BIT);
		host_read(reg_addr_t'(`ADDR_STATUS), data);
		check_value("status_after_flush", 32'd0, data);
		host_read(reg_addr_t'(`ADDR_MSG), data);
		check_value("msg_after_flush", 32'd0, data);

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
hdl/pixel_pkg.sv
hdl/host_pkg.sv
hdl/stream_reg.sv
hdl/colour_classifier.sv
hdl/scan_counter.sv
hdl/extent_tracker.sv
hdl/msg_writer.sv
hdl/host_port.sv
hdl/imgproc_top.sv
testbench/imgproc_assert.sv
testbench/imgproc_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := imgproc_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
